/* bench/ext_mem_checker.sv */
`timescale 1ns/10ps
`default_nettype none

// Watches the DUT ports, predicts read data from a shadow memory
// and checks the AXI valid rules
module ext_mem_checker
   import ext_mem_pkg::*;
(
   input  wire                    clk,
   input  wire                    arst_n,
   input  wire                    i_valid,
   input  wire  [ADDR_W-1:0]      i_addr,
   input  wire  [DATA_W-1:0]      i_rdata,
   input  wire                    i_ready,
   input  wire                    d_valid,
   input  wire  [ADDR_W-1:0]      d_addr,
   input  wire  [DATA_W-1:0]      d_wdata,
   input  wire  [STRB_W-1:0]      d_wstrb,
   input  wire  [DATA_W-1:0]      d_rdata,
   input  wire                    d_ready,
   input  wire                    axi_arvalid,
   input  wire                    axi_arready,
   input  wire  [AXI_LEN_W-1:0]   axi_arlen,
   input  wire  [AXI_SIZE_W-1:0]  axi_arsize,
   input  wire  [AXI_BURST_W-1:0] axi_arburst,
   input  wire                    axi_awvalid,
   input  wire                    axi_awready,
   input  wire  [AXI_LEN_W-1:0]   axi_awlen,
   input  wire  [AXI_SIZE_W-1:0]  axi_awsize,
   input  wire  [AXI_BURST_W-1:0] axi_awburst,
   input  wire                    axi_wvalid,
   input  wire                    axi_wready,
   input  wire                    axi_wlast,
   input  wire                    axi_rready,
   input  wire                    axi_bready,
   output int                     err_count,
   output int                     ar_count
);

   logic [DATA_W-1:0] shadow [256];
   logic              seen_req;
   logic              prev_ar;
   logic              prev_aw;
   logic              prev_w;

   // Memory starts with a word built from its own index
   function automatic logic [DATA_W-1:0] initial_word(input logic [7:0] idx);
      return {idx ^ 8'h5a, ~idx, idx + 8'h31, idx};
   endfunction

   initial begin
      for (int i = 0; i < 256; i++) begin
         shadow[i] = initial_word(8'(i));
      end
      err_count = 0;
      ar_count  = 0;
      seen_req  = 1'b0;
      prev_ar   = 1'b0;
      prev_aw   = 1'b0;
      prev_w    = 1'b0;
   end

   always @(posedge clk) begin
      if (arst_n) begin
         if (i_valid || d_valid) seen_req <= 1'b1;
         // Quiet outputs until the first request
         if (!seen_req && !i_valid && !d_valid &&
             (i_ready || d_ready || axi_arvalid || axi_awvalid || axi_wvalid ||
              axi_rready || axi_bready)) begin
            $display("ready or AXI valid output high after reset with no request");
            err_count <= err_count + 1;
         end
         // Instruction read against shadow
         if (i_ready && i_rdata !== shadow[i_addr[9:2]]) begin
            $display("mismatch i_rdata at %h: got %h expected %h",
                     i_addr, i_rdata, shadow[i_addr[9:2]]);
            err_count <= err_count + 1;
         end
         if (d_ready && d_valid) begin
            if (d_wstrb == '0) begin
               if (d_rdata !== shadow[d_addr[9:2]]) begin
                  $display("mismatch d_rdata at %h: got %h expected %h",
                           d_addr, d_rdata, shadow[d_addr[9:2]]);
                  err_count <= err_count + 1;
               end
            end else begin
               // Only the strobed bytes change
               for (int b = 0; b < STRB_W; b++) begin
                  if (d_wstrb[b]) shadow[d_addr[9:2]][8*b +: 8] <= d_wdata[8*b +: 8];
               end
            end
         end
         if (d_ready && !d_valid) begin
            $display("d_ready pulsed with no data request pending");
            err_count <= err_count + 1;
         end
         if (axi_arvalid && axi_arready) ar_count <= ar_count + 1;
         // One beat of four bytes, INCR type
         if (axi_arvalid && {axi_arlen, axi_arsize, axi_arburst} !== {8'h00, 3'h2, 2'h1}) begin
            $display("mismatch axi_arlen/arsize/arburst: got %h/%h/%h expected 00/2/1",
                     axi_arlen, axi_arsize, axi_arburst);
            err_count <= err_count + 1;
         end
         if (axi_awvalid && {axi_awlen, axi_awsize, axi_awburst} !== {8'h00, 3'h2, 2'h1}) begin
            $display("mismatch axi_awlen/awsize/awburst: got %h/%h/%h expected 00/2/1",
                     axi_awlen, axi_awsize, axi_awburst);
            err_count <= err_count + 1;
         end
         // Valid never drops before its ready
         if (prev_ar && !axi_arvalid) begin
            $display("arvalid dropped before arready");
            err_count <= err_count + 1;
         end
         if (prev_aw && !axi_awvalid) begin
            $display("awvalid dropped before awready");
            err_count <= err_count + 1;
         end
         if (prev_w && !axi_wvalid) begin
            $display("wvalid dropped before wready");
            err_count <= err_count + 1;
         end
         if (axi_wvalid && !axi_wlast) begin
            $display("wlast low during a write beat");
            err_count <= err_count + 1;
         end
         prev_ar <= axi_arvalid && !axi_arready;
         prev_aw <= axi_awvalid && !axi_awready;
         prev_w  <= axi_wvalid && !axi_wready;
      end
   end

endmodule

`default_nettype wire

/* bench/ext_mem_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module ext_mem_tb;
   import ext_mem_pkg::*;

   // Row kinds
   localparam int P_I    = 0;
   localparam int P_D    = 1;
   localparam int P_PAIR = 2;

   logic                   clk;
   logic                   arst_n;
   logic                   i_valid;
   logic [ADDR_W-1:0]      i_addr;
   logic [DATA_W-1:0]      i_rdata;
   logic                   i_ready;
   logic                   d_valid;
   logic [ADDR_W-1:0]      d_addr;
   logic [DATA_W-1:0]      d_wdata;
   logic [STRB_W-1:0]      d_wstrb;
   logic [DATA_W-1:0]      d_rdata;
   logic                   d_ready;
   logic [ADDR_W-1:0]      axi_awaddr;
   logic [AXI_LEN_W-1:0]   axi_awlen;
   logic [AXI_SIZE_W-1:0]  axi_awsize;
   logic [AXI_BURST_W-1:0] axi_awburst;
   logic                   axi_awvalid;
   logic                   axi_awready;
   logic [DATA_W-1:0]      axi_wdata;
   logic [STRB_W-1:0]      axi_wstrb;
   logic                   axi_wlast;
   logic                   axi_wvalid;
   logic                   axi_wready;
   logic [AXI_RESP_W-1:0]  axi_bresp;
   logic                   axi_bvalid;
   logic                   axi_bready;
   logic [ADDR_W-1:0]      axi_araddr;
   logic [AXI_LEN_W-1:0]   axi_arlen;
   logic [AXI_SIZE_W-1:0]  axi_arsize;
   logic [AXI_BURST_W-1:0] axi_arburst;
   logic                   axi_arvalid;
   logic                   axi_arready;
   logic [DATA_W-1:0]      axi_rdata;
   logic [AXI_RESP_W-1:0]  axi_rresp;
   logic                   axi_rlast;
   logic                   axi_rvalid;
   logic                   axi_rready;
   int                     err_count;
   int                     ar_count;

   // Stimulus table columns
   int                row_kind [$];
   logic              row_wr [$];
   logic [ADDR_W-1:0] row_addr [$];
   logic [DATA_W-1:0] row_wdata [$];
   logic [STRB_W-1:0] row_wstrb [$];
   int                row_ar [$];

   logic [DATA_W-1:0] mem [256];
   integer            seed;
   int                bench_errors;
   int                cycles;
   int                cycle_limit;

   ext_mem ext_mem_inst (.*);
   ext_mem_checker checker_inst (.*);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic logic [DATA_W-1:0] initial_word(input logic [7:0] idx);
      return {idx ^ 8'h5a, ~idx, idx + 8'h31, idx};
   endfunction

   function automatic int rand_delay();
      return int'($unsigned($random(seed)) % 4);
   endfunction

   // AXI read slave
   initial begin : read_slave
      logic [ADDR_W-1:0] ra;
      forever begin
         @(negedge clk);
         if (axi_arvalid) begin
            repeat (rand_delay()) @(negedge clk);
            axi_arready = 1'b1;
            @(posedge clk);
            ra = axi_araddr;
            @(negedge clk);
            axi_arready = 1'b0;
            repeat (rand_delay()) @(negedge clk);
            axi_rdata  = mem[ra[9:2]];
            axi_rvalid = 1'b1;
            axi_rlast  = 1'b1;
            @(negedge clk);
            axi_rvalid = 1'b0;
            axi_rlast  = 1'b0;
         end
      end
   end

   // AXI write slave, address first then data then response
   initial begin : write_slave
      logic [ADDR_W-1:0] wa;
      forever begin
         @(negedge clk);
         if (axi_awvalid) begin
            repeat (rand_delay()) @(negedge clk);
            axi_awready = 1'b1;
            @(posedge clk);
            wa = axi_awaddr;
            @(negedge clk);
            axi_awready = 1'b0;
            repeat (rand_delay()) @(negedge clk);
            axi_wready = 1'b1;
            @(posedge clk);
            for (int b = 0; b < STRB_W; b++) begin
               if (axi_wstrb[b]) mem[wa[9:2]][8*b +: 8] = axi_wdata[8*b +: 8];
            end
            @(negedge clk);
            axi_wready = 1'b0;
            repeat (rand_delay()) @(negedge clk);
            axi_bvalid = 1'b1;
            @(negedge clk);
            axi_bvalid = 1'b0;
         end
      end
   end

   task automatic add_row(input int kind, input logic wr, input logic [ADDR_W-1:0] addr,
                          input logic [DATA_W-1:0] wdata, input logic [STRB_W-1:0] wstrb,
                          input int ar);
      row_kind.push_back(kind);
      row_wr.push_back(wr);
      row_addr.push_back(addr);
      row_wdata.push_back(wdata);
      row_wstrb.push_back(wstrb);
      row_ar.push_back(ar);
   endtask

   // Valid held one cycle past ready, the DUT tolerates that
   task automatic instr_access(input logic [ADDR_W-1:0] addr, output int waited);
      waited  = 1;
      i_valid = 1'b1;
      i_addr  = addr;
      @(negedge clk);
      while (!i_ready) begin
         waited++;
         @(negedge clk);
      end
      @(negedge clk);
      i_valid = 1'b0;
   endtask

   task automatic data_access(input logic wr, input logic [ADDR_W-1:0] addr,
                              input logic [DATA_W-1:0] wdata, input logic [STRB_W-1:0] wstrb);
      d_valid = 1'b1;
      d_addr  = addr;
      d_wdata = wdata;
      d_wstrb = wr ? wstrb : '0;
      @(negedge clk);
      while (!d_ready) @(negedge clk);
      @(negedge clk);
      d_valid = 1'b0;
      d_wstrb = '0;
   endtask

   // Watchdog
   initial begin
      cycles = 0;
      forever begin
         @(posedge clk);
         cycles++;
         if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout after %0d cycles", cycles);
            $display("Testbench failed");
            $finish;
         end
      end
   end

   initial begin
      int ar_before;
      int waited;
      seed = 32'hb28fd31b;
      cycle_limit = 0;
      bench_errors = 0;
      arst_n = 1'b0;
      i_valid = 1'b0;
      i_addr = '0;
      d_valid = 1'b0;
      d_addr = '0;
      d_wdata = '0;
      d_wstrb = '0;
      axi_awready = 1'b0;
      axi_wready = 1'b0;
      axi_bresp = '0;
      axi_bvalid = 1'b0;
      axi_arready = 1'b0;
      axi_rdata = '0;
      axi_rresp = '0;
      axi_rlast = 1'b0;
      axi_rvalid = 1'b0;
      for (int i = 0; i < 256; i++) mem[i] = initial_word(8'(i));
      // Data writes stay in 0x200-0x3ff, instruction reads below
      add_row(P_D, 1'b1, 16'h0200, 32'h11223344, 4'hf, 0);
      add_row(P_D, 1'b0, 16'h0200, '0, '0, 1);
      add_row(P_D, 1'b1, 16'h0204, 32'haabbccdd, 4'h5, 0);
      add_row(P_D, 1'b0, 16'h0204, '0, '0, 1);
      add_row(P_D, 1'b1, 16'h0208, 32'hdeadbeef, 4'h8, 0);
      add_row(P_D, 1'b0, 16'h0208, '0, '0, 1);
      add_row(P_I, 1'b0, 16'h0010, '0, '0, 4);
      add_row(P_I, 1'b0, 16'h0014, '0, '0, 0);
      add_row(P_I, 1'b0, 16'h001c, '0, '0, 0);
      add_row(P_I, 1'b0, 16'h0040, '0, '0, 4);
      // Pairs put the data side at the address with bit 9 set
      add_row(P_PAIR, 1'b0, 16'h0080, '0, '0, 5);
      add_row(P_PAIR, 1'b1, 16'h00c4, 32'h0badf00d, 4'h3, 4);
      add_row(P_D, 1'b0, 16'h02c4, '0, '0, 1);
      add_row(P_PAIR, 1'b0, 16'h0084, '0, '0, 1);
      // Same line index, other tag, then back
      add_row(P_I, 1'b0, 16'h1010, '0, '0, 4);
      add_row(P_I, 1'b0, 16'h0010, '0, '0, 4);
      add_row(P_D, 1'b0, 16'h03fc, '0, '0, 1);
      cycle_limit = row_kind.size() * 40;
      repeat (5) @(negedge clk);
      arst_n = 1'b1;
      repeat (3) @(negedge clk);
      for (int r = 0; r < row_kind.size(); r++) begin
         ar_before = ar_count;
         waited = 0;
         case (row_kind[r])
            P_I: instr_access(row_addr[r], waited);
            P_D: data_access(row_wr[r], row_addr[r], row_wdata[r], row_wstrb[r]);
            default: begin
               fork
                  instr_access(row_addr[r], waited);
                  data_access(row_wr[r], row_addr[r] | 16'h0200, row_wdata[r], row_wstrb[r]);
               join
            end
         endcase
         if (ar_count - ar_before != row_ar[r]) begin
            $display("mismatch ar handshakes row %0d: got %h expected %h",
                     r, ar_count - ar_before, row_ar[r]);
            bench_errors++;
         end
         if (row_kind[r] == P_I && row_ar[r] == 0 && waited != 1) begin
            $display("instruction hit in row %0d took %0d cycles instead of one", r, waited);
            bench_errors++;
         end
         @(negedge clk);
      end
      $display("errors: checker %0d, bench %0d", err_count, bench_errors);
      if (err_count == 0 && bench_errors == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* files.f */
logic/ext_mem_pkg.sv
logic/icache.sv
logic/bus_merge.sv
logic/axi_rd_engine.sv
logic/axi_wr_engine.sv
logic/ext_mem.sv
bench/ext_mem_checker.sv
bench/ext_mem_tb.sv

/* logic/axi_rd_engine.sv */
`timescale 1ns/10ps
`default_nettype none

// Native read to single-beat AXI read
module axi_rd_engine
   import ext_mem_pkg::*;
(
   input  wire                    clk,
   input  wire                    arst_n,
   // Native side
   input  wire                    valid,
   input  wire  [ADDR_W-1:0]      addr,
   output logic [DATA_W-1:0]      rdata,
   output logic                   ready,
   // AXI read address
   output logic [ADDR_W-1:0]      axi_araddr,
   output logic [AXI_LEN_W-1:0]   axi_arlen,
   output logic [AXI_SIZE_W-1:0]  axi_arsize,
   output logic [AXI_BURST_W-1:0] axi_arburst,
   output logic                   axi_arvalid,
   input  wire                    axi_arready,
   // AXI read data, rresp not looked at
   input  wire  [DATA_W-1:0]      axi_rdata,
   input  wire  [AXI_RESP_W-1:0]  axi_rresp,
   input  wire                    axi_rlast,
   input  wire                    axi_rvalid,
   output logic                   axi_rready
);

   typedef enum logic [1:0] {S_IDLE, S_ADDR, S_DATA} state_t;

   state_t state;
   logic   accept;

   // Skip the ready cycle, the master still holds valid there
   assign accept = (state == S_IDLE) && valid && !ready;

   assign axi_arlen   = AXI_LEN_SINGLE;
   assign axi_arsize  = AXI_SIZE_WORD;
   assign axi_arburst = AXI_BURST_INCR;
   assign axi_arvalid = (state == S_ADDR);
   assign axi_rready  = (state == S_DATA);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state <= S_IDLE;
         ready <= 1'b0;
      end else begin
         ready <= 1'b0;
         case (state)
            S_IDLE: if (accept) state <= S_ADDR;
            S_ADDR: if (axi_arready) state <= S_DATA;
            S_DATA: begin
               if (axi_rvalid && axi_rlast) begin
                  ready <= 1'b1;
                  state <= S_IDLE;
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   // Address and read word
   always_ff @(posedge clk) begin
      if (accept) axi_araddr <= addr;
      if (axi_rvalid && axi_rready) rdata <= axi_rdata;
   end

   // Address stays offered and steady until taken
   a_ar_held: assert property (@(posedge clk) disable iff (!arst_n)
      (axi_arvalid && !axi_arready) |=> (axi_arvalid && $stable(axi_araddr)));

endmodule

`default_nettype wire

/* logic/axi_wr_engine.sv */
`timescale 1ns/10ps
`default_nettype none

// Native write to single-beat AXI write
// Address and data channels complete independently
module axi_wr_engine
   import ext_mem_pkg::*;
(
   input  wire                    clk,
   input  wire                    arst_n,
   // Native side
   input  wire                    valid,
   input  wire  [ADDR_W-1:0]      addr,
   input  wire  [DATA_W-1:0]      wdata,
   input  wire  [STRB_W-1:0]      wstrb,
   output logic                   ready,
   // AXI write address
   output logic [ADDR_W-1:0]      axi_awaddr,
   output logic [AXI_LEN_W-1:0]   axi_awlen,
   output logic [AXI_SIZE_W-1:0]  axi_awsize,
   output logic [AXI_BURST_W-1:0] axi_awburst,
   output logic                   axi_awvalid,
   input  wire                    axi_awready,
   // AXI write data
   output logic [DATA_W-1:0]      axi_wdata,
   output logic [STRB_W-1:0]      axi_wstrb,
   output logic                   axi_wlast,
   output logic                   axi_wvalid,
   input  wire                    axi_wready,
   // AXI write response, bresp not looked at
   input  wire  [AXI_RESP_W-1:0]  axi_bresp,
   input  wire                    axi_bvalid,
   output logic                   axi_bready
);

   typedef enum logic [1:0] {S_IDLE, S_SEND, S_RESP} state_t;

   state_t state;
   logic   accept;
   logic   aw_done;
   logic   w_done;
   logic   aw_hs;
   logic   w_hs;

   assign accept = (state == S_IDLE) && valid && !ready;

   assign axi_awlen   = AXI_LEN_SINGLE;
   assign axi_awsize  = AXI_SIZE_WORD;
   assign axi_awburst = AXI_BURST_INCR;
   // Each channel drops on its own handshake
   assign axi_awvalid = (state == S_SEND) && !aw_done;
   assign axi_wvalid  = (state == S_SEND) && !w_done;
   // Single beat is always the last
   assign axi_wlast   = axi_wvalid;
   assign axi_bready  = (state == S_RESP);

   assign aw_hs = axi_awvalid && axi_awready;
   assign w_hs  = axi_wvalid && axi_wready;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state   <= S_IDLE;
         aw_done <= 1'b0;
         w_done  <= 1'b0;
         ready   <= 1'b0;
      end else begin
         ready <= 1'b0;
         case (state)
            S_IDLE: begin
               if (accept) begin
                  aw_done <= 1'b0;
                  w_done  <= 1'b0;
                  state   <= S_SEND;
               end
            end
            S_SEND: begin
               if (aw_hs) aw_done <= 1'b1;
               if (w_hs) w_done <= 1'b1;
               // Both channels through, wait for the response
               if ((aw_done || aw_hs) && (w_done || w_hs)) state <= S_RESP;
            end
            S_RESP: begin
               if (axi_bvalid) begin
                  ready <= 1'b1;
                  state <= S_IDLE;
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   // Write payload
   always_ff @(posedge clk) begin
      if (accept) begin
         axi_awaddr <= addr;
         axi_wdata  <= wdata;
         axi_wstrb  <= wstrb;
      end
   end

   // Data beat stays offered and steady until taken
   a_w_held: assert property (@(posedge clk) disable iff (!arst_n)
      (axi_wvalid && !axi_wready) |=> (axi_wvalid && $stable(axi_wdata)));

endmodule

`default_nettype wire

/* logic/bus_merge.sv */
`timescale 1ns/10ps
`default_nettype none

// Two-master round-robin merge onto one native bus
// Grant is combinational and locked until the slave answers
module bus_merge
   import ext_mem_pkg::*;
(
   input  wire                clk,
   input  wire                arst_n,
   // Cache back end
   input  wire                c_valid,
   input  wire  [ADDR_W-1:0]  c_addr,
   output logic [DATA_W-1:0]  c_rdata,
   output logic               c_ready,
   // Data port
   input  wire                d_valid,
   input  wire  [ADDR_W-1:0]  d_addr,
   input  wire  [DATA_W-1:0]  d_wdata,
   input  wire  [STRB_W-1:0]  d_wstrb,
   output logic [DATA_W-1:0]  d_rdata,
   output logic               d_ready,
   // Merged bus
   output logic               m_valid,
   output logic [ADDR_W-1:0]  m_addr,
   output logic [DATA_W-1:0]  m_wdata,
   output logic [STRB_W-1:0]  m_wstrb,
   input  wire  [DATA_W-1:0]  m_rdata,
   input  wire                m_ready
);

   logic locked;
   logic lock_d;
   logic last_d;
   logic pick_d;
   logic sel_d;

   // Data port takes a tie only when the cache won last
   assign pick_d = d_valid && (!c_valid || !last_d);
   assign sel_d  = locked ? lock_d : pick_d;

   assign m_valid = sel_d ? d_valid : c_valid;
   assign m_addr  = sel_d ? d_addr  : c_addr;
   // Cache side never writes
   assign m_wdata = sel_d ? d_wdata : '0;
   assign m_wstrb = sel_d ? d_wstrb : '0;

   // Read word goes to both, ready only to the owner
   assign c_rdata = m_rdata;
   assign d_rdata = m_rdata;
   assign c_ready = m_ready && !sel_d;
   assign d_ready = m_ready && sel_d;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         locked <= 1'b0;
         lock_d <= 1'b0;
         last_d <= 1'b0;
      end else if (m_valid && m_ready) begin
         // Release and remember the winner
         locked <= 1'b0;
         last_d <= sel_d;
      end else if (m_valid) begin
         locked <= 1'b1;
         lock_d <= sel_d;
      end
   end

   // Owner does not change while a transfer is pending
   a_grant_held: assert property (@(posedge clk) disable iff (!arst_n)
      (m_valid && !m_ready) |=> (sel_d == $past(sel_d)));

endmodule

`default_nettype wire

/* logic/ext_mem.sv */
`timescale 1ns/10ps
`default_nettype none

// External memory front end
// Instruction cache and data port share one bus, split by strobe to AXI
module ext_mem
   import ext_mem_pkg::*;
(
   input  wire                    clk,
   input  wire                    arst_n,
   // Instruction port
   input  wire                    i_valid,
   input  wire  [ADDR_W-1:0]      i_addr,
   output logic [DATA_W-1:0]      i_rdata,
   output logic                   i_ready,
   // Data port
   input  wire                    d_valid,
   input  wire  [ADDR_W-1:0]      d_addr,
   input  wire  [DATA_W-1:0]      d_wdata,
   input  wire  [STRB_W-1:0]      d_wstrb,
   output logic [DATA_W-1:0]      d_rdata,
   output logic                   d_ready,
   // AXI write address
   output logic [ADDR_W-1:0]      axi_awaddr,
   output logic [AXI_LEN_W-1:0]   axi_awlen,
   output logic [AXI_SIZE_W-1:0]  axi_awsize,
   output logic [AXI_BURST_W-1:0] axi_awburst,
   output logic                   axi_awvalid,
   input  wire                    axi_awready,
   // AXI write data and response
   output logic [DATA_W-1:0]      axi_wdata,
   output logic [STRB_W-1:0]      axi_wstrb,
   output logic                   axi_wlast,
   output logic                   axi_wvalid,
   input  wire                    axi_wready,
   input  wire  [AXI_RESP_W-1:0]  axi_bresp,
   input  wire                    axi_bvalid,
   output logic                   axi_bready,
   // AXI read address
   output logic [ADDR_W-1:0]      axi_araddr,
   output logic [AXI_LEN_W-1:0]   axi_arlen,
   output logic [AXI_SIZE_W-1:0]  axi_arsize,
   output logic [AXI_BURST_W-1:0] axi_arburst,
   output logic                   axi_arvalid,
   input  wire                    axi_arready,
   // AXI read data
   input  wire  [DATA_W-1:0]      axi_rdata,
   input  wire  [AXI_RESP_W-1:0]  axi_rresp,
   input  wire                    axi_rlast,
   input  wire                    axi_rvalid,
   output logic                   axi_rready
);

   // Cache back end
   logic              c_valid;
   logic [ADDR_W-1:0] c_addr;
   logic [DATA_W-1:0] c_rdata;
   logic              c_ready;

   // Merged bus
   logic              m_valid;
   logic [ADDR_W-1:0] m_addr;
   logic [DATA_W-1:0] m_wdata;
   logic [STRB_W-1:0] m_wstrb;
   logic [DATA_W-1:0] m_rdata;
   logic              m_ready;

   // Engine handshakes
   logic m_write;
   logic rd_valid;
   logic rd_ready;
   logic wr_valid;
   logic wr_ready;

   icache icache_inst (
      .mem_valid (c_valid),
      .mem_addr  (c_addr),
      .mem_rdata (c_rdata),
      .mem_ready (c_ready),
      .*
   );

   // Port names match the local c, d and m buses
   bus_merge bus_merge_inst (.*);

   // Any strobe bit set means write
   assign m_write  = |m_wstrb;
   assign rd_valid = m_valid && !m_write;
   assign wr_valid = m_valid && m_write;
   // Only the busy engine ever pulses ready
   assign m_ready  = rd_ready || wr_ready;

   axi_rd_engine rd_engine_inst (
      .valid (rd_valid),
      .addr  (m_addr),
      .rdata (m_rdata),
      .ready (rd_ready),
      .*
   );

   axi_wr_engine wr_engine_inst (
      .valid (wr_valid),
      .addr  (m_addr),
      .wdata (m_wdata),
      .wstrb (m_wstrb),
      .ready (wr_ready),
      .*
   );

endmodule

`default_nettype wire

/* logic/ext_mem_pkg.sv */
`default_nettype none

// Shared widths and constants for the external memory front end
package ext_mem_pkg;

   // Byte address on the native ports and on AXI
   localparam int ADDR_W = 16;
   // Word width on every bus
   localparam int DATA_W = 32;
   localparam int STRB_W = DATA_W / 8;

   // Address split is tag, line, word, byte
   localparam int BYTE_OFF_W = 2;
   localparam int WORD_OFF_W = 2;
   localparam int LINE_OFF_W = 4;
   localparam int TAG_W      = ADDR_W - LINE_OFF_W - WORD_OFF_W - BYTE_OFF_W;

   // Cache geometry
   localparam int N_LINES        = 2 ** LINE_OFF_W;
   localparam int WORDS_PER_LINE = 2 ** WORD_OFF_W;

   // AXI field widths
   localparam int AXI_LEN_W   = 8;
   localparam int AXI_SIZE_W  = 3;
   localparam int AXI_BURST_W = 2;
   localparam int AXI_RESP_W  = 2;

   // Single beat, so len is zero
   localparam logic [AXI_LEN_W-1:0]   AXI_LEN_SINGLE = '0;
   // Four bytes per beat
   localparam logic [AXI_SIZE_W-1:0]  AXI_SIZE_WORD  = 3'd2;
   localparam logic [AXI_BURST_W-1:0] AXI_BURST_INCR = 2'b01;

endpackage

`default_nettype wire

/* logic/icache.sv */
`timescale 1ns/10ps
`default_nettype none

// Direct-mapped read-only instruction cache
// Miss fills the whole line with one back-end read per word
module icache
   import ext_mem_pkg::*;
(
   input  wire                clk,
   input  wire                arst_n,
   // Instruction port
   input  wire                i_valid,
   input  wire  [ADDR_W-1:0]  i_addr,
   output logic [DATA_W-1:0]  i_rdata,
   output logic               i_ready,
   // Back end, reads only
   output logic               mem_valid,
   output logic [ADDR_W-1:0]  mem_addr,
   input  wire  [DATA_W-1:0]  mem_rdata,
   input  wire                mem_ready
);

   typedef enum logic [1:0] {S_IDLE, S_FILL, S_RESP} state_t;

   // Tag, valid and data arrays
   logic [TAG_W-1:0]   tag_mem [N_LINES];
   logic [N_LINES-1:0] line_valid;
   logic [DATA_W-1:0]  data_mem [N_LINES*WORDS_PER_LINE];

   state_t                state;
   logic [WORD_OFF_W-1:0] fill_cnt;

   // Request address fields
   logic [TAG_W-1:0]      req_tag;
   logic [LINE_OFF_W-1:0] req_line;
   logic [WORD_OFF_W-1:0] req_word;
   logic                  hit;
   logic                  fill_last;

   assign req_word = i_addr[BYTE_OFF_W +: WORD_OFF_W];
   assign req_line = i_addr[BYTE_OFF_W+WORD_OFF_W +: LINE_OFF_W];
   assign req_tag  = i_addr[ADDR_W-1 -: TAG_W];

   assign hit = line_valid[req_line] && (tag_mem[req_line] == req_tag);

   // Last word of the line coming back
   assign fill_last = mem_ready && (fill_cnt == WORD_OFF_W'(WORDS_PER_LINE - 1));

   // Fill walks the line from word zero
   assign mem_addr = {req_tag, req_line, fill_cnt, {BYTE_OFF_W{1'b0}}};

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state      <= S_IDLE;
         fill_cnt   <= '0;
         mem_valid  <= 1'b0;
         i_ready    <= 1'b0;
         line_valid <= '0;
      end else begin
         // One-cycle ready pulse
         i_ready <= 1'b0;
         case (state)
            S_IDLE: begin
               if (i_valid && hit) begin
                  i_ready <= 1'b1;
                  state   <= S_RESP;
               end else if (i_valid) begin
                  // Line invalid until every word is back
                  line_valid[req_line] <= 1'b0;
                  fill_cnt  <= '0;
                  mem_valid <= 1'b1;
                  state     <= S_FILL;
               end
            end
            S_FILL: begin
               if (fill_last) begin
                  line_valid[req_line] <= 1'b1;
                  mem_valid <= 1'b0;
                  i_ready   <= 1'b1;
                  state     <= S_RESP;
               end else if (mem_ready) begin
                  fill_cnt <= fill_cnt + 1'b1;
               end
            end
            default: begin
               // Requester still holds valid in the ready cycle
               state <= S_IDLE;
            end
         endcase
      end
   end

   // Arrays and read word
   always_ff @(posedge clk) begin
      if (state == S_IDLE && i_valid && hit) begin
         i_rdata <= data_mem[{req_line, req_word}];
      end
      if (state == S_FILL && mem_ready) begin
         data_mem[{req_line, fill_cnt}] <= mem_rdata;
         // Grab the requested word as it passes
         if (fill_cnt == req_word) begin
            i_rdata <= mem_rdata;
         end
         if (fill_last) begin
            tag_mem[req_line] <= req_tag;
         end
      end
   end

   // Hit answer comes with no back-end request and no back-end ready
   a_hit_no_fill: assert property (@(posedge clk) disable iff (!arst_n)
      (i_ready && !$past(mem_valid)) |-> (!mem_valid && !mem_ready));

   // Requester keeps its address through a line fill
   a_fill_addr_stable: assert property (@(posedge clk) disable iff (!arst_n)
      (state == S_FILL) |-> (i_valid && $stable(i_addr)));

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Compile and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module ext_mem_tb -o ext_mem_sim
if [ $? -ne 0 ]; then
   echo "compile failed"
   exit 1
fi

out=$(./obj_dir/ext_mem_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -q "^Testbench passed$"; then
   exit 0
fi
exit 1
